// ==== tb.f ====
src/mul_pkg.sv
src/partial_product_gen.sv
src/dadda_stage.sv
src/dadda_tree.sv
src/product_adder.sv
src/mul_top.sv
verification/mul_assertions.sv
verification/tb_mul_top.sv

// ==== Makefile ====
TOP = tb_mul_top
SIM = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when the file list or one of its sources changes
$(SIM): tb.f $(shell cat tb.f)
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_mul_top.sv ====
`timescale 1ns/1ps

module tb_mul_top;

    import mul_pkg::*;

    localparam int clk_period       = 40;
    localparam int drive_delay      = 2;
    localparam int reset_cycles     = 8;
    localparam int idle_cycles      = 5;
    localparam int seed             = 83741;

    localparam int n_isolated       = 46;
    localparam int iso_slots        = 6;
    localparam int n_burst          = 2000;
    localparam int n_gappy          = 500;
    localparam int max_gap          = 3;
    localparam int n_mid            = 20;
    localparam int n_after          = 50;
    localparam int mid_reset_cycles = 4;

    // cycles the whole run can take, each request counted with its worst-case gap
    localparam int num_slots = reset_cycles + 2 * idle_cycles + n_isolated * iso_slots
                             + n_burst + (n_gappy + n_after) * (max_gap + 1)
                             + n_mid + mid_reset_cycles + 4 * (3 + 1);
    localparam int watchdog_ns = (num_slots + 3 + 20) * clk_period;

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    operands_t in_ops;
    logic      out_valid;
    product_t  out_prod;

    product_t  exp_q [$];
    int        cyc_q [$];
    int        cycle = 0;

    mul_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ops    (in_ops),
        .out_valid (out_valid),
        .out_prod  (out_prod)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // full 64-bit unsigned product, split into the two words
    function automatic product_t ref_mul(operand_t a, operand_t b);
        logic [prod_width-1:0] full;
        product_t p;
        full = {{op_width{1'b0}}, a} * {{op_width{1'b0}}, b};
        p.hi = full[prod_width-1:op_width];
        p.lo = full[op_width-1:0];
        return p;
    endfunction

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("FAILED at time %0t: %s = %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_valid(string name, logic got, logic exp);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("FAILED at time %0t: %s = %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    // one-cycle request, the expected product is queued with the cycle that holds it
    task automatic send_request(operand_t a, operand_t b);
        in_valid = 1'b1;
        in_ops.a = a;
        in_ops.b = b;
        exp_q.push_back(ref_mul(a, b));
        cyc_q.push_back(cycle);
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
        begin
            next_cycle();
        end
    endtask

    task automatic send_isolated(operand_t a, operand_t b);
        send_request(a, b);
        wait_drain();
        next_cycle();
    endtask

    task automatic send_with_gaps(int count);
        int gap;
        repeat (count)
        begin
            send_request($urandom(), $urandom());
            gap = $urandom_range(max_gap, 0);
            repeat (gap) next_cycle();
        end
    endtask

    task automatic pulse_reset(int cycles);
        arst_n = 1'b0;
        exp_q.delete();
        cyc_q.delete();
        repeat (cycles) next_cycle();
        arst_n = 1'b1;
    endtask

    task automatic run_corner_cases();
        send_isolated(32'h0000_0000, 32'h0000_0000);
        send_isolated(32'h0000_0000, 32'hffff_ffff);
        send_isolated(32'hffff_ffff, 32'h0000_0000);
        send_isolated(32'h0000_0001, 32'h0000_0001);
        send_isolated(32'h0000_0001, 32'hffff_ffff);
        send_isolated(32'hffff_ffff, 32'h0000_0001);
        // high word is fffffffe here
        send_isolated(32'hffff_ffff, 32'hffff_ffff);
        for (int i = 0; i < op_width; i++)
        begin
            send_isolated(operand_t'(1) << i, operand_t'(1) << ((i * 7) % op_width));
        end
    endtask

    // dense operands that load columns 45 to 48
    task automatic run_column_patterns();
        send_isolated(32'hffff_ffff, 32'hffff_0000);
        send_isolated(32'hffff_0000, 32'hffff_ffff);
        send_isolated(32'haaaa_aaaa, 32'h5555_5555);
        send_isolated(32'h5555_5555, 32'haaaa_aaaa);
        send_isolated(32'haaaa_aaaa, 32'haaaa_aaaa);
        send_isolated(32'h5555_5555, 32'h5555_5555);
        send_isolated(32'hffff_0000, 32'hffff_0000);
    endtask

    // outputs are looked at mid-cycle, well away from the register updates
    always @(negedge clk)
    begin : compare
        logic exp_valid;
        exp_valid = (cyc_q.size() > 0) && (cyc_q[0] + 3 == cycle);
        check_valid("out_valid", out_valid, exp_valid);
        if (out_valid)
        begin
            check_word("out_prod.hi", out_prod.hi, exp_q[0].hi);
            check_word("out_prod.lo", out_prod.lo, exp_q[0].lo);
            void'(exp_q.pop_front());
            void'(cyc_q.pop_front());
        end
    end

    initial
    begin
        #(watchdog_ns);
        stop_with_failure("timeout: not all products arrived");
    end

    initial
    begin
        void'($urandom(seed));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_ops   = '0;
        repeat (reset_cycles) next_cycle();
        arst_n = 1'b1;

        // quiet period, any stray out_valid is caught by the compare block
        repeat (idle_cycles) next_cycle();

        run_corner_cases();
        run_column_patterns();

        repeat (n_burst) send_request($urandom(), $urandom());
        wait_drain();

        send_with_gaps(n_gappy);
        wait_drain();

        // reset lands while the pipeline is full
        repeat (n_mid) send_request($urandom(), $urandom());
        pulse_reset(mid_reset_cycles);
        send_with_gaps(n_after);
        wait_drain();

        repeat (idle_cycles) next_cycle();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== verification/mul_assertions.sv ====
`timescale 1ns/1ps

module mul_assertions (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic out_valid
);

    // pipeline depth of mul_top
    localparam int latency = 3;

    // every accepted request comes out three edges later
    a_result_follows: assert property (
        @(posedge clk) disable iff (!arst_n)
        $past(in_valid, latency) |-> out_valid
    )
    else $error("out_valid missing %0d cycles after in_valid", latency);

    // checked mid-cycle since reset is asynchronous
    a_quiet_in_reset: assert property (
        @(negedge clk) !arst_n |-> !out_valid
    )
    else $error("out_valid high while arst_n is low");

    a_no_extra_result: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(in_valid, latency)
    )
    else $error("out_valid without a request %0d cycles earlier", latency);

endmodule

bind mul_top mul_assertions i_mul_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

// ==== src/mul_top.sv ====
`timescale 1ns/1ps

module mul_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  mul_pkg::operands_t  in_ops,
    output logic                out_valid,
    output mul_pkg::product_t   out_prod
);

    import mul_pkg::*;

    logic  heap_valid;
    heap_t heap;
    logic  rows_valid;
    rows_t rows;

    partial_product_gen i_partial_product_gen (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ops     (in_ops),
        .heap_valid (heap_valid),
        .heap       (heap)
    );

    dadda_tree i_dadda_tree (
        .clk        (clk),
        .arst_n     (arst_n),
        .heap_valid (heap_valid),
        .heap       (heap),
        .rows_valid (rows_valid),
        .rows       (rows)
    );

    product_adder i_product_adder (
        .clk        (clk),
        .arst_n     (arst_n),
        .rows_valid (rows_valid),
        .rows       (rows),
        .out_valid  (out_valid),
        .out_prod   (out_prod)
    );

endmodule

// ==== src/product_adder.sv ====
`timescale 1ns/1ps

module product_adder (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rows_valid,
    input  mul_pkg::rows_t      rows,
    output logic                out_valid,
    output mul_pkg::product_t   out_prod
);

    import mul_pkg::*;

    logic [op_width:0] lo_sum;
    word_t             hi_sum;

    // low half first, its carry goes into the high half
    assign lo_sum = {1'b0, rows.row_a[op_width-1:0]} + {1'b0, rows.row_b[op_width-1:0]};

    // carry out of the top bit is dropped, the product fits in 64 bits
    assign hi_sum = rows.row_a[prod_width-1:op_width]
                  + rows.row_b[prod_width-1:op_width]
                  + word_t'(lo_sum[op_width]);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
            out_prod  <= '0;
        end
        else
        begin
            out_valid   <= rows_valid;
            out_prod.hi <= hi_sum;
            out_prod.lo <= lo_sum[op_width-1:0];
        end
    end

endmodule

// ==== src/dadda_tree.sv ====
`timescale 1ns/1ps

module dadda_tree (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            heap_valid,
    input  mul_pkg::heap_t  heap,
    output logic            rows_valid,
    output mul_pkg::rows_t  rows
);

    import mul_pkg::*;

    heap_t stage_heap [num_stages+1];
    rows_t rows_d;

    assign stage_heap[0] = heap;

    // heights 28, 19, 13, 9, 6, 4, 3, 2
    for (genvar s = 0; s < num_stages; s++)
    begin : g_stage
        dadda_stage #(
            .stage (s)
        ) i_stage (
            .heap_in  (stage_heap[s]),
            .heap_out (stage_heap[s+1])
        );
    end

    // only the two bottom bits of each column are left
    always_comb
    begin
        for (int c = 0; c < num_cols; c++)
        begin
            rows_d.row_a[c] = stage_heap[num_stages][c][0];
            rows_d.row_b[c] = stage_heap[num_stages][c][1];
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rows_valid <= 1'b0;
            rows       <= '0;
        end
        else
        begin
            rows_valid <= heap_valid;
            rows       <= rows_d;
        end
    end

endmodule

// ==== src/dadda_stage.sv ====
`timescale 1ns/1ps

module dadda_stage #(
    parameter int stage = 0
) (
    input  mul_pkg::heap_t heap_in,
    output mul_pkg::heap_t heap_out
);

    import mul_pkg::*;

    // one small count per column
    typedef logic [num_cols-1:0][7:0] count_vec_t;

    // carries entering each column during stage s, given the heights entering it
    function automatic count_vec_t carries_in(int s, count_vec_t h);
        count_vec_t cin;
        int carry;
        int tot;
        int excess;
        cin   = '0;
        carry = 0;
        for (int c = 0; c < num_cols; c++)
        begin
            cin[c] = 8'(carry);
            tot    = int'(h[c]) + carry;
            excess = (tot > dadda_target(s)) ? tot - dadda_target(s) : 0;
            // every full adder and the half adder send one carry up
            carry  = excess / 2 + excess % 2;
        end
        return cin;
    endfunction

    // heights entering stage s, walking the earlier stages from the initial heap
    function automatic count_vec_t heights_in(int s);
        count_vec_t h;
        count_vec_t cin;
        int tot;
        for (int c = 0; c < num_cols; c++)
        begin
            h[c] = 8'(initial_height(c));
        end
        for (int k = 0; k < s; k++)
        begin
            cin = carries_in(k, h);
            for (int c = 0; c < num_cols; c++)
            begin
                tot  = int'(h[c]) + int'(cin[c]);
                h[c] = 8'((tot > dadda_target(k)) ? dadda_target(k) : tot);
            end
        end
        return h;
    endfunction

    localparam count_vec_t h_in_tab = heights_in(stage);
    localparam count_vec_t cin_tab  = carries_in(stage, h_in_tab);

    column_t carry_out [num_cols];

    for (genvar c = 0; c < num_cols; c++)
    begin : g_col
        localparam int h      = int'(h_in_tab[c]);
        localparam int ci     = int'(cin_tab[c]);
        localparam int excess = (h + ci > dadda_target(stage)) ? h + ci - dadda_target(stage) : 0;
        localparam int nfa    = excess / 2;
        localparam int nha    = excess % 2;
        localparam int used   = 3 * nfa + 2 * nha;

        column_t bits;
        column_t fa_sum;
        column_t fa_carry;
        column_t from_below;
        logic    ha_sum;
        logic    ha_carry;

        assign bits = heap_in[c];

        // full adders take the bottom bits three at a time
        always_comb
        begin
            fa_sum   = '0;
            fa_carry = '0;
            for (int k = 0; k < nfa; k++)
            begin
                fa_sum[k]   = bits[3*k] ^ bits[3*k+1] ^ bits[3*k+2];
                fa_carry[k] = (bits[3*k] & bits[3*k+1])
                            | (bits[3*k+2] & (bits[3*k] ^ bits[3*k+1]));
            end
        end

        if (nha != 0)
        begin : g_ha
            assign ha_sum   = bits[used-2] ^ bits[used-1];
            assign ha_carry = bits[used-2] & bits[used-1];
        end
        else
        begin : g_no_ha
            assign ha_sum   = 1'b0;
            assign ha_carry = 1'b0;
        end

        assign carry_out[c] = fa_carry | (column_t'(ha_carry) << nfa);

        if (c == 0)
        begin : g_bottom
            assign from_below = '0;
        end
        else
        begin : g_upper
            assign from_below = carry_out[c-1];
        end

        // carries from below first, then the new sums, then untouched bits
        assign heap_out[c] = from_below
                           | ((fa_sum | (column_t'(ha_sum) << nfa)) << ci)
                           | ((bits >> used) << (ci + nfa + nha));
    end

endmodule

// ==== src/partial_product_gen.sv ====
`timescale 1ns/1ps

module partial_product_gen (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  mul_pkg::operands_t  in_ops,
    output logic                heap_valid,
    output mul_pkg::heap_t      heap
);

    import mul_pkg::*;

    operands_t ops_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            heap_valid <= 1'b0;
            ops_q      <= '0;
        end
        else
        begin
            heap_valid <= in_valid;
            ops_q      <= in_ops;
        end
    end

    // a[i] & b[j] lands in column i+j
    // upper columns start counting at the term with the highest a bit
    always_comb
    begin
        heap = '0;
        for (int i = 0; i < op_width; i++)
        begin
            for (int j = 0; j < op_width; j++)
            begin
                if (i + j < op_width)
                begin
                    heap[i+j][j] = ops_q.a[i] & ops_q.b[j];
                end
                else
                begin
                    heap[i+j][op_width-1-i] = ops_q.a[i] & ops_q.b[j];
                end
            end
        end
    end

endmodule

// ==== src/mul_pkg.sv ====
package mul_pkg;

    localparam int op_width   = 32;
    localparam int prod_width = 2 * op_width;
    localparam int num_cols   = prod_width;
    localparam int max_height = op_width;
    localparam int num_stages = 8;

    typedef logic [op_width-1:0]   operand_t;
    typedef logic [op_width-1:0]   word_t;
    typedef logic [prod_width-1:0] row_t;
    typedef logic [max_height-1:0] column_t;

    // one column per product bit, bits packed from index 0 upward
    typedef column_t [num_cols-1:0] heap_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
    } operands_t;

    typedef struct packed {
        row_t row_a;
        row_t row_b;
    } rows_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } product_t;

    // column height allowed after a stage, from d(j+1) = floor(1.5 * d(j)) with d(0) = 2
    function automatic int dadda_target(int stage);
        int d;
        d = 2;
        for (int j = 0; j < num_stages - 1 - stage; j++)
        begin
            d = (d * 3) / 2;
        end
        return d;
    endfunction

    // height of a column in the partial-product heap
    function automatic int initial_height(int col);
        if (col < op_width)
        begin
            return col + 1;
        end
        if (col < prod_width - 1)
        begin
            return prod_width - 1 - col;
        end
        return 0;
    endfunction

endpackage
